//--- Bender.yml
package:
  name: cpu16_pipeline

sources:
  - common/cpu_pkg.sv
  - common/id_ex_if.sv
  - decode/instr_decoder.sv
  - decode/reg_file.sv
  - src/fetch_unit.sv
  - src/id_ex_stage.sv
  - src/execute_unit.sv
  - src/cpu_top.sv
  - target: simulation
    files:
      - sim/cpu_tb.sv

//--- common/cpu_pkg.sv
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_OR  = 4'h3,
        OP_ADI = 4'h4,
        OP_LWD = 4'h5,
        OP_SWD = 4'h6,
        OP_BEQ = 4'h7,
        OP_NOP = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    // Decoded control strobes that travel with an instruction into EX
    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    reg_write;
        logic    mem_to_reg;
    } ctrl_t;

    localparam ctrl_t CTRL_NONE = '{alu_op: ALU_ADD, default: 1'b0};

    // Instruction field positions
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 12;
    localparam int RS_MSB  = 11;
    localparam int RS_LSB  = 10;
    localparam int RT_MSB  = 9;
    localparam int RT_LSB  = 8;
    localparam int RD_MSB  = 7;
    localparam int RD_LSB  = 6;
    localparam int IMM_MSB = 7;
    localparam int IMM_LSB = 0;

    localparam word_t INSTR_NOP = {OP_NOP, 12'h000};

endpackage

//--- common/id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;

    cpu_pkg::word_t    pc;
    cpu_pkg::word_t    rdata1;
    cpu_pkg::word_t    rdata2;
    cpu_pkg::word_t    imm;
    cpu_pkg::reg_idx_t dest;
    cpu_pkg::ctrl_t    ctrl;

    modport src (
        output pc,
        output rdata1,
        output rdata2,
        output imm,
        output dest,
        output ctrl
    );

    modport dst (
        input pc,
        input rdata1,
        input rdata2,
        input imm,
        input dest,
        input ctrl
    );

endinterface

//--- decode/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_pkg::word_t    if_instr,
    output cpu_pkg::reg_idx_t rs_idx,
    output cpu_pkg::reg_idx_t rt_idx,
    output cpu_pkg::reg_idx_t dest,
    output cpu_pkg::word_t    imm,
    output cpu_pkg::ctrl_t    ctrl
);

    cpu_pkg::opcode_t  opcode;
    cpu_pkg::reg_idx_t rd_idx;

    assign opcode = cpu_pkg::opcode_t'(if_instr[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB]);
    assign rs_idx = if_instr[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB];
    assign rt_idx = if_instr[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB];
    assign rd_idx = if_instr[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];

    assign imm = {{8{if_instr[cpu_pkg::IMM_MSB]}},
                  if_instr[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB]};

    always_comb begin
        ctrl = cpu_pkg::CTRL_NONE;
        dest = rd_idx;
        case (opcode)
            cpu_pkg::OP_ADD: begin
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_SUB: begin
                ctrl.alu_op    = cpu_pkg::ALU_SUB;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_AND: begin
                ctrl.alu_op    = cpu_pkg::ALU_AND;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_OR: begin
                ctrl.alu_op    = cpu_pkg::ALU_OR;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_ADI: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                dest             = rt_idx;
            end
            cpu_pkg::OP_LWD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                dest             = rt_idx;
            end
            cpu_pkg::OP_SWD: begin
                // Address comes out of the ALU as rs plus the immediate
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            cpu_pkg::OP_BEQ: begin
                ctrl.branch = 1'b1;
            end
            default: begin
                ctrl = cpu_pkg::CTRL_NONE;
            end
        endcase
    end

endmodule

//--- decode/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::reg_idx_t rs_idx,
    input  cpu_pkg::reg_idx_t rt_idx,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2,
    input  logic              wb_en,
    input  cpu_pkg::reg_idx_t wb_idx,
    input  cpu_pkg::word_t    wb_data
);

    cpu_pkg::word_t regs [4];

    // No write-through, a write is seen by ID one cycle after it retires
    assign rdata1 = regs[rs_idx];
    assign rdata2 = regs[rt_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

endmodule

//--- sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [15:0] RESET_PC = 16'h0040;
    localparam int PROG_LEN = 21;
    localparam int MAX_CYCLES = PROG_LEN * 3 + 20;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [15:0] imem_addr;
    logic [15:0] imem_data;
    logic [15:0] dmem_addr;
    logic [15:0] dmem_wdata;
    logic        dmem_read;
    logic        dmem_write;
    logic [15:0] dmem_rdata;
    logic        wb_valid;
    logic [1:0]  wb_idx;
    logic [15:0] wb_data;

    logic [15:0] rom [PROG_LEN];
    logic [15:0] rom_addr;
    logic [15:0] dram [65536];
    logic [15:0] ref_mem [65536];
    logic [15:0] ref_regs [4];
    logic [1:0]  exp_wb_idx [$];
    logic [15:0] exp_wb_data [$];
    logic [15:0] exp_ld_addr [$];
    logic [15:0] exp_st_addr [$];
    logic [15:0] exp_st_data [$];
    int          wb_errors;
    int          ld_errors;
    int          st_errors;
    int          other_errors;
    int          cycle;

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_rdata (dmem_rdata),
        .wb_valid   (wb_valid),
        .wb_idx     (wb_idx),
        .wb_data    (wb_data)
    );

    always #20 clk = ~clk;

    assign rom_addr = imem_addr - RESET_PC;

    // Past the end of the program the ROM returns NOPs
    assign imem_data  = (rom_addr < PROG_LEN) ? rom[rom_addr] : {cpu_pkg::OP_NOP, 12'h000};
    assign dmem_rdata = dram[dmem_addr];

    always @(posedge clk) begin
        if (dmem_write) begin
            dram[dmem_addr] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] fill_word(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ (a * 16'd7) ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] enc(input logic [3:0] op, input logic [1:0] rs,
                                        input logic [1:0] rt, input logic [7:0] low);
        return {op, rs, rt, low};
    endfunction

    function automatic logic [15:0] rtype(input logic [3:0] op, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [1:0] rd);
        return enc(op, rs, rt, {rd, 6'h00});
    endfunction

    task automatic load_program();
        logic [31:0] s;
        logic [7:0]  imm [5];
        s = 32'hb9fe0a14;
        for (int i = 0; i < 5; i++) begin
            s = lcg_next(s);
            imm[i] = s[23:16];
        end
        // One offset surely positive and one surely negative, so r1 and r2 differ
        imm[0] = {2'b01, imm[0][5:0]};
        imm[1] = {1'b1, imm[1][6:0]};
        rom[0]  = enc(cpu_pkg::OP_ADI, 2'd0, 2'd1, imm[0]);
        rom[1]  = enc(cpu_pkg::OP_ADI, 2'd0, 2'd2, imm[1]);
        rom[2]  = enc(cpu_pkg::OP_NOP, 2'd0, 2'd0, 8'h00);
        rom[3]  = rtype(cpu_pkg::OP_ADD, 2'd1, 2'd2, 2'd3);
        rom[4]  = rtype(cpu_pkg::OP_SUB, 2'd1, 2'd2, 2'd0);
        rom[5]  = rtype(cpu_pkg::OP_AND, 2'd1, 2'd2, 2'd3);
        rom[6]  = rtype(cpu_pkg::OP_OR, 2'd1, 2'd2, 2'd0);
        rom[7]  = enc(cpu_pkg::OP_SWD, 2'd1, 2'd2, imm[2]);
        rom[8]  = enc(cpu_pkg::OP_NOP, 2'd0, 2'd0, 8'h00);
        rom[9]  = enc(cpu_pkg::OP_LWD, 2'd1, 2'd3, imm[2]);
        rom[10] = enc(cpu_pkg::OP_NOP, 2'd0, 2'd0, 8'h00);
        // Taken, r3 was just loaded with r2, so 12 and 13 must never retire
        rom[11] = enc(cpu_pkg::OP_BEQ, 2'd3, 2'd2, 8'd2);
        rom[12] = enc(cpu_pkg::OP_ADI, 2'd0, 2'd0, 8'd1);
        rom[13] = enc(cpu_pkg::OP_SWD, 2'd1, 2'd2, 8'd0);
        rom[14] = enc(cpu_pkg::OP_BEQ, 2'd1, 2'd2, 8'd5);
        rom[15] = enc(cpu_pkg::OP_ADI, 2'd1, 2'd0, imm[3]);
        rom[16] = rtype(cpu_pkg::OP_ADD, 2'd1, 2'd1, 2'd2);
        rom[17] = rtype(cpu_pkg::OP_SUB, 2'd0, 2'd1, 2'd3);
        rom[18] = enc(cpu_pkg::OP_LWD, 2'd2, 2'd1, imm[4]);
        rom[19] = enc(cpu_pkg::OP_NOP, 2'd0, 2'd0, 8'h00);
        rom[20] = rtype(cpu_pkg::OP_OR, 2'd1, 2'd0, 2'd3);
    endtask

    task automatic expect_wb(input logic [1:0] idx, input logic [15:0] data);
        ref_regs[idx] = data;
        exp_wb_idx.push_back(idx);
        exp_wb_data.push_back(data);
    endtask

    task automatic run_reference();
        int          pc;
        int          steps;
        logic [15:0] ins;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] addr;
        pc = 0;
        steps = 0;
        for (int r = 0; r < 4; r++) begin
            ref_regs[r] = 16'h0000;
        end
        while (pc < PROG_LEN && steps < 100) begin
            ins = rom[pc];
            a = ref_regs[ins[11:10]];
            b = ref_regs[ins[9:8]];
            imm = {{8{ins[7]}}, ins[7:0]};
            addr = a + imm;
            pc++;
            steps++;
            case (ins[15:12])
                cpu_pkg::OP_ADD: expect_wb(ins[7:6], a + b);
                cpu_pkg::OP_SUB: expect_wb(ins[7:6], a - b);
                cpu_pkg::OP_AND: expect_wb(ins[7:6], a & b);
                cpu_pkg::OP_OR:  expect_wb(ins[7:6], a | b);
                cpu_pkg::OP_ADI: expect_wb(ins[9:8], addr);
                cpu_pkg::OP_LWD: begin
                    exp_ld_addr.push_back(addr);
                    expect_wb(ins[9:8], ref_mem[addr]);
                end
                cpu_pkg::OP_SWD: begin
                    ref_mem[addr] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                cpu_pkg::OP_BEQ: begin
                    if (a == b) begin
                        pc = pc + int'($signed(imm));
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    always @(negedge clk) begin
        if (!arst_n || cycle == 0) begin
            assert (imem_addr == RESET_PC) else begin
                $display("error imem_addr expected 0x%h got 0x%h", RESET_PC, imem_addr);
                other_errors++;
            end
        end
        // The first instruction reaches EX in the third cycle after reset
        if (!arst_n || cycle < 2) begin
            assert (!dmem_read && !dmem_write && !wb_valid && !UUT.branch_taken) else begin
                $display("a strobe is high before the first writeback");
                other_errors++;
            end
        end
        if (arst_n && wb_valid) begin
            if (exp_wb_data.size() == 0) begin
                $display("writeback to r%0d that the program never makes", wb_idx);
                other_errors++;
            end else begin
                assert (wb_idx == exp_wb_idx[0]) else begin
                    $display("error wb_idx expected 0x%h got 0x%h", exp_wb_idx[0], wb_idx);
                    wb_errors++;
                end
                assert (wb_data == exp_wb_data[0]) else begin
                    $display("error wb_data expected 0x%h got 0x%h", exp_wb_data[0], wb_data);
                    wb_errors++;
                end
                void'(exp_wb_idx.pop_front());
                void'(exp_wb_data.pop_front());
            end
        end
        if (arst_n && dmem_read) begin
            if (exp_ld_addr.size() == 0) begin
                $display("load from 0x%h that the program never makes", dmem_addr);
                other_errors++;
            end else begin
                assert (dmem_addr == exp_ld_addr[0]) else begin
                    $display("error dmem_addr expected 0x%h got 0x%h", exp_ld_addr[0], dmem_addr);
                    ld_errors++;
                end
                void'(exp_ld_addr.pop_front());
            end
        end
        if (arst_n && dmem_write) begin
            if (exp_st_data.size() == 0) begin
                $display("store to 0x%h that the program never makes", dmem_addr);
                other_errors++;
            end else begin
                assert (dmem_addr == exp_st_addr[0]) else begin
                    $display("error dmem_addr expected 0x%h got 0x%h", exp_st_addr[0], dmem_addr);
                    st_errors++;
                end
                assert (dmem_wdata == exp_st_data[0]) else begin
                    $display("error dmem_wdata expected 0x%h got 0x%h", exp_st_data[0],
                             dmem_wdata);
                    st_errors++;
                end
                void'(exp_st_addr.pop_front());
                void'(exp_st_data.pop_front());
            end
        end
    end

    initial begin
        arst_n = 1'b0;
        wb_errors = 0;
        ld_errors = 0;
        st_errors = 0;
        other_errors = 0;
        cycle = 0;
        load_program();
        for (int i = 0; i < 65536; i++) begin
            dram[i] = fill_word(i[15:0]);
            ref_mem[i] = fill_word(i[15:0]);
        end
        run_reference();
        repeat (2) @(posedge clk);
        #5 arst_n = 1'b1;
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        if (exp_wb_data.size() != 0 || exp_ld_addr.size() != 0 || exp_st_data.size() != 0) begin
            $display("program did not finish, %0d writebacks, %0d loads, %0d stores missing",
                     exp_wb_data.size(), exp_ld_addr.size(), exp_st_data.size());
            other_errors++;
        end
        $display("errors: writeback %0d, load %0d, store %0d, other %0d", wb_errors, ld_errors,
                 st_errors, other_errors);
        if (wb_errors + ld_errors + st_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sources.f
common/cpu_pkg.sv
common/id_ex_if.sv
decode/instr_decoder.sv
decode/reg_file.sv
src/fetch_unit.sv
src/id_ex_stage.sv
src/execute_unit.sv
src/cpu_top.sv
sim/cpu_tb.sv

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              arst_n,
    output cpu_pkg::word_t    imem_addr,
    input  cpu_pkg::word_t    imem_data,
    output cpu_pkg::word_t    dmem_addr,
    output cpu_pkg::word_t    dmem_wdata,
    output logic              dmem_read,
    output logic              dmem_write,
    input  cpu_pkg::word_t    dmem_rdata,
    output logic              wb_valid,
    output cpu_pkg::reg_idx_t wb_idx,
    output cpu_pkg::word_t    wb_data
);

    cpu_pkg::word_t    if_pc;
    cpu_pkg::word_t    if_instr;
    cpu_pkg::reg_idx_t rs_idx;
    cpu_pkg::reg_idx_t rt_idx;
    logic              branch_taken;
    cpu_pkg::word_t    branch_target;

    id_ex_if dec_bus ();
    id_ex_if ex_bus ();

    assign dec_bus.pc = if_pc;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .if_pc         (if_pc),
        .if_instr      (if_instr)
    );

    instr_decoder u_decoder (
        .if_instr (if_instr),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .dest     (dec_bus.dest),
        .imm      (dec_bus.imm),
        .ctrl     (dec_bus.ctrl)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rdata1  (dec_bus.rdata1),
        .rdata2  (dec_bus.rdata2),
        .wb_en   (wb_valid),
        .wb_idx  (wb_idx),
        .wb_data (wb_data)
    );

    id_ex_stage u_id_ex (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (branch_taken),
        .dec    (dec_bus),
        .ex     (ex_bus)
    );

    execute_unit u_execute (
        .ex            (ex_bus),
        .dmem_addr     (dmem_addr),
        .dmem_wdata    (dmem_wdata),
        .dmem_read     (dmem_read),
        .dmem_write    (dmem_write),
        .dmem_rdata    (dmem_rdata),
        .wb_en         (wb_valid),
        .wb_idx        (wb_idx),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

//--- src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    id_ex_if.dst              ex,
    output cpu_pkg::word_t    dmem_addr,
    output cpu_pkg::word_t    dmem_wdata,
    output logic              dmem_read,
    output logic              dmem_write,
    input  cpu_pkg::word_t    dmem_rdata,
    output logic              wb_en,
    output cpu_pkg::reg_idx_t wb_idx,
    output cpu_pkg::word_t    wb_data,
    output logic              branch_taken,
    output cpu_pkg::word_t    branch_target
);

    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_result;

    assign op_b = ex.ctrl.alu_src_imm ? ex.imm : ex.rdata2;

    always_comb begin
        case (ex.ctrl.alu_op)
            cpu_pkg::ALU_ADD: alu_result = ex.rdata1 + op_b;
            cpu_pkg::ALU_SUB: alu_result = ex.rdata1 - op_b;
            cpu_pkg::ALU_AND: alu_result = ex.rdata1 & op_b;
            cpu_pkg::ALU_OR:  alu_result = ex.rdata1 | op_b;
            default:          alu_result = '0;
        endcase
    end

    // Branch target is relative to the word after the branch
    assign branch_taken  = ex.ctrl.branch && (ex.rdata1 == ex.rdata2);
    assign branch_target = ex.pc + 16'd1 + ex.imm;

    // Loads and stores decode with the immediate on operand B and an add,
    // so the ALU result is already rs plus the immediate
    assign dmem_addr  = alu_result;
    assign dmem_wdata = ex.rdata2;
    assign dmem_read  = ex.ctrl.mem_read;
    assign dmem_write = ex.ctrl.mem_write;

    assign wb_en   = ex.ctrl.reg_write;
    assign wb_idx  = ex.dest;
    assign wb_data = ex.ctrl.mem_to_reg ? dmem_rdata : alu_result;

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           branch_taken,
    input  cpu_pkg::word_t branch_target,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t if_pc,
    output cpu_pkg::word_t if_instr
);

    cpu_pkg::word_t pc;

    assign imem_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= RESET_PC;
            if_instr <= cpu_pkg::INSTR_NOP;
        end else if (branch_taken) begin
            // The word fetched this cycle is on the wrong path
            pc       <= branch_target;
            if_instr <= cpu_pkg::INSTR_NOP;
        end else begin
            pc       <= pc + 16'd1;
            if_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if_pc <= pc;
    end

endmodule

//--- src/id_ex_stage.sv
`timescale 1ns/1ps

module id_ex_stage (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,
    id_ex_if.dst   dec,
    id_ex_if.src   ex
);

    // Only the strobes decide whether the slot does anything
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex.ctrl <= cpu_pkg::CTRL_NONE;
        end else if (flush) begin
            ex.ctrl <= cpu_pkg::CTRL_NONE;
        end else begin
            ex.ctrl <= dec.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex.pc     <= dec.pc;
        ex.rdata1 <= dec.rdata1;
        ex.rdata2 <= dec.rdata2;
        ex.imm    <= dec.imm;
        ex.dest   <= dec.dest;
    end

endmodule
